// File: mm2s_dma.f
design/dma_cfg_pkg.sv
design/dma_bus_pkg.sv
design/mm2s_job_ctrl.sv
design/rd_burst_issuer.sv
design/rd_credit_ctrl.sv
design/rdata_fifo.sv
design/mm2s_dma.sv
verification/tb_clk_gen.sv
verification/tb_mm2s_dma.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mm2s_dma \
	-f mm2s_dma.f \
	-o tb_mm2s_dma

./obj_dir/tb_mm2s_dma | tee sim.log

if grep -qx "Testbench passed" sim.log
then
	exit 0
else
	exit 1
fi

// File: verification/mm2s_stimulus.txt
# base len ready_lvl lat_lvl beats last_keep, all hex
# len is bytes minus 1, levels 0..3 set the axis_ready stall and rvalid gap rate
00001000 0000003f 0 0 008 ff
00002000 00000007 1 1 001 ff
00003000 00000002 2 1 001 07
00004000 000001ff 0 2 040 ff
00010008 0000004c 3 0 00a 1f
00020000 00000fff 2 2 200 ff
00030010 00000095 3 3 013 3f
00040000 0000017b 1 3 030 0f
7ffffff8 00000000 0 0 001 01
00050020 000000ff 3 2 020 ff
00060040 00000041 1 0 009 03

// File: verification/tb_mm2s_dma.sv
`default_nettype none

module tb_mm2s_dma;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int JOB_TIMEOUT = 20000;   // cycles per job
	localparam int MAX_LINES = 1000;

	logic        clk;
	logic        rst_n;
	logic [31:0] in_buf_base;
	logic [31:0] in_buf_len;
	logic        mm2s_start;
	logic        mm2s_idle;
	logic        mm2s_done;
	logic [31:0] araddr;
	logic [7:0]  arlen;
	logic        arvalid;
	logic        arready;
	logic [63:0] rdata;
	logic        rlast;
	logic        rvalid;
	logic        rready;
	logic [63:0] axis_data;
	logic [7:0]  axis_keep;
	logic        axis_last;
	logic        axis_valid;
	logic        axis_ready;

	// memory slave, bursts in order of acceptance
	logic [31:0] ar_addr_q [$];
	int          ar_len_q [$];
	int          r_beat;         // beat within head burst
	logic        r_taken;        // r handshake seen this cycle
	// current job and its expectations
	logic [31:0] cur_base;
	int          exp_beats;
	logic [7:0]  exp_keep;
	int          ready_lvl;      // axis_ready stall level 0..3
	int          lat_lvl;        // rvalid gap level 0..3
	logic [31:0] next_ar_addr;
	int          req_beats;
	int          stream_idx;
	int          done_cnt;
	int          in_flight;      // ar accepted minus rlast
	int          slots_used;     // ar accepted minus bursts streamed
	int          errors;
	int          jobs;
	logic        stalled;        // a wait ran out or the file was missing
	logic [15:0] lfsr;

	tb_clk_gen u_clk (.clk(clk));

	mm2s_dma dut (.*);

	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]);   // one step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error @%0t: %s", $time, msg);
	endtask

	// negedge: inputs and outputs both settled, handshakes known
	task automatic sample_cycle();
		logic [31:0] a;
		int          left;
		logic        final_idx;
		@(negedge clk);
		r_taken = 1'b0;
		if (arvalid && arready)
		begin
			left = exp_beats - req_beats;
			if (left <= 0)
				report_error("burst requested beyond job length");
			if (left > 0 && araddr != next_ar_addr)
				report_error($sformatf("araddr %h, expected %h", araddr, next_ar_addr));
			if (left > 0 && int'(arlen) != (left > 8 ? 8 : left) - 1)
				report_error($sformatf("arlen %0d with %0d beats left", arlen, left));
			ar_addr_q.push_back(araddr);
			ar_len_q.push_back(int'(arlen));
			req_beats += int'(arlen) + 1;
			next_ar_addr = next_ar_addr + 32'd64;   // one full burst
			in_flight++;
			slots_used++;
			if (in_flight > 4)
				report_error($sformatf("%0d bursts in flight", in_flight));
			if (slots_used > 8)
				report_error($sformatf("%0d buffer slots reserved", slots_used));
		end
		if (rvalid && rready)
		begin
			r_taken = 1'b1;
			if (rlast)
			begin
				void'(ar_addr_q.pop_front());
				void'(ar_len_q.pop_front());
				r_beat = 0;
				in_flight--;
			end
			else
				r_beat++;
		end
		final_idx = (stream_idx == exp_beats - 1);
		if (axis_valid && axis_ready && stream_idx >= exp_beats)
			report_error("stream beat beyond job length");
		if (axis_valid && axis_ready && stream_idx < exp_beats)
		begin
			a = cur_base + 32'(8 * stream_idx);   // word at base + 8i
			if (axis_data != {a, ~a})
				report_error($sformatf("beat %0d data %h", stream_idx, axis_data));
			if (axis_last != final_idx)
				report_error($sformatf("beat %0d last %b", stream_idx, axis_last));
			if (axis_keep != (final_idx ? exp_keep : 8'hff))
				report_error($sformatf("beat %0d keep %h", stream_idx, axis_keep));
			if (stream_idx % 8 == 7 || final_idx)
				slots_used--;   // a whole burst left the buffer
			stream_idx++;
		end
		if (mm2s_done != (axis_valid && axis_ready && final_idx))
			report_error($sformatf("done %b off the final beat", mm2s_done));
		if (mm2s_done)
			done_cnt++;
	endtask

	// 1 ns after the rising edge
	task automatic drive_cycle();
		logic [31:0] a;
		int          v;
		@(posedge clk);
		#1;
		take_bits(2, v);
		axis_ready = (v >= ready_lvl);
		take_bits(1, v);
		arready = (lat_lvl == 0) || (v == 1);
		if (!rvalid || r_taken)   // a pending beat stays put
		begin
			take_bits(2, v);
			if (ar_addr_q.size() > 0 && v >= lat_lvl)
			begin
				a = ar_addr_q[0] + 32'(8 * r_beat);
				rdata = {a, ~a};
				rlast = (r_beat == ar_len_q[0]);
				rvalid = 1'b1;
			end
			else
				rvalid = 1'b0;
		end
	endtask

	task automatic run_job(input logic [31:0] base, input logic [31:0] len, input int rdy,
		input int lat, input int beats, input logic [7:0] keep);
		int wait_cnt;
		cur_base = base;
		exp_beats = beats;
		exp_keep = keep;
		ready_lvl = rdy;
		lat_lvl = lat;
		next_ar_addr = base;
		req_beats = 0;
		stream_idx = 0;
		done_cnt = 0;
		in_buf_base = base;
		in_buf_len = len;
		mm2s_start = 1'b1;
		sample_cycle();
		drive_cycle();
		mm2s_start = 1'b0;
		wait_cnt = 0;
		while (done_cnt == 0 && wait_cnt < JOB_TIMEOUT)
		begin
			mm2s_start = 1'b0;
			if (wait_cnt == 2 && !mm2s_idle)
			begin
				in_buf_base = base ^ 32'h0008_0000;   // start while running, ignored
				in_buf_len = 32'h3f;
				mm2s_start = 1'b1;
			end
			sample_cycle();
			if (wait_cnt == 0 && !arvalid)
				report_error("arvalid not up the cycle after start");
			drive_cycle();
			wait_cnt++;
		end
		mm2s_start = 1'b0;
		if (done_cnt == 0)
		begin
			$display("timeout: job at %h never signalled done", base);
			stalled = 1'b1;
		end
		else
		begin
			if (!mm2s_idle)
				report_error("idle not back the cycle after done");
			sample_cycle();   // quiet cycle, nothing more may come
			drive_cycle();
			if (done_cnt != 1)
				report_error($sformatf("done pulsed %0d times", done_cnt));
			if (stream_idx != exp_beats)
				report_error($sformatf("%0d beats streamed, %0d expected", stream_idx, exp_beats));
			if (req_beats != exp_beats)
				report_error($sformatf("%0d beats requested, %0d expected", req_beats, exp_beats));
			if (in_flight != 0 || slots_used != 0 || ar_addr_q.size() != 0)
				report_error("bursts left over after done");
		end
		jobs++;
	endtask

	initial
	begin
		int          fd;
		int          n;
		int          line_cnt;
		logic [31:0] f_base;
		logic [31:0] f_len;
		int          f_rdy;
		int          f_lat;
		int          f_beats;
		logic [7:0]  f_keep;
		logic [8*200-1:0] skip_line;
		errors = 0;
		jobs = 0;
		stalled = 1'b0;
		lfsr = 16'd72;
		rst_n = 1'b0;
		mm2s_start = 1'b0;
		in_buf_base = '0;
		in_buf_len = '0;
		arready = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		rvalid = 1'b0;
		axis_ready = 1'b0;
		r_beat = 0;
		r_taken = 1'b0;
		cur_base = '0;
		exp_beats = 0;
		exp_keep = '0;
		ready_lvl = 0;
		lat_lvl = 0;
		next_ar_addr = '0;
		req_beats = 0;
		stream_idx = 0;
		done_cnt = 0;
		in_flight = 0;
		slots_used = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		sample_cycle();
		if (mm2s_idle !== 1'b1 || arvalid !== 1'b0 || axis_valid !== 1'b0 ||
			mm2s_done !== 1'b0 || rready !== 1'b1)
			report_error("outputs wrong after reset");
		drive_cycle();

		fd = $fopen("verification/mm2s_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("stimulus file verification/mm2s_stimulus.txt could not be opened");
			stalled = 1'b1;
		end
		line_cnt = 0;
		while (fd != 0 && !stalled && !$feof(fd) && line_cnt < MAX_LINES)
		begin
			n = $fscanf(fd, " %h %h %h %h %h %h", f_base, f_len, f_rdy, f_lat, f_beats, f_keep);
			if (n == 6)
				run_job(f_base, f_len, f_rdy, f_lat, f_beats, f_keep);
			else
				n = $fgets(skip_line, fd);   // comment line
			line_cnt++;
		end
		if (fd != 0)
			$fclose(fd);

		$display("%0d jobs run, %0d errors", jobs, errors);
		if (errors == 0 && !stalled && jobs > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam real HALF_PERIOD = 2.0;   // 4 ns period

	initial
		clk = 1'b0;

	always
		#HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: design/mm2s_dma.sv
`default_nettype none

module mm2s_dma (
	input  wire                              clk,
	input  wire                              rst_n,
	// job command
	input  wire [dma_cfg_pkg::ADDR_W-1:0]    in_buf_base,
	input  wire [31:0]                       in_buf_len,   // bytes minus 1
	input  wire                              mm2s_start,
	output logic                             mm2s_idle,
	output logic                             mm2s_done,
	// axi read address
	output logic [dma_cfg_pkg::ADDR_W-1:0]   araddr,
	output logic [dma_cfg_pkg::LEN_W-1:0]    arlen,
	output logic                             arvalid,
	input  wire                              arready,
	// axi read data
	input  wire [dma_cfg_pkg::DATA_W-1:0]    rdata,
	input  wire                              rlast,
	input  wire                              rvalid,
	output logic                             rready,
	// stream out
	output logic [dma_cfg_pkg::DATA_W-1:0]   axis_data,
	output logic [dma_cfg_pkg::KEEP_W-1:0]   axis_keep,
	output logic                             axis_last,
	output logic                             axis_valid,
	input  wire                              axis_ready
);

	logic                       job_load;
	dma_bus_pkg::job_t          job;
	logic                       launch_ok;
	logic                       launch;        // ar handshake
	dma_bus_pkg::ar_beat_t      ar;
	dma_bus_pkg::r_beat_t       r_in;
	dma_bus_pkg::r_beat_t       head;
	logic                       head_valid;
	logic                       pop;           // head leaves buffer
	dma_bus_pkg::axis_beat_t    axis;
	logic                       rlast_done;
	logic                       burst_drained;

	assign araddr = ar.addr;
	assign arlen  = ar.len;

	assign r_in          = '{data: rdata, last: rlast};
	assign rlast_done    = rvalid & rready & rlast;   // burst fully returned
	assign burst_drained = pop & head.last;           // burst fully streamed

	assign axis_data = axis.data;
	assign axis_keep = axis.keep;
	assign axis_last = axis.last;

	mm2s_job_ctrl u_job_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (mm2s_start),
		.base       (in_buf_base),
		.len        (in_buf_len),
		.idle       (mm2s_idle),
		.done       (mm2s_done),
		.job_load   (job_load),
		.job        (job),
		.head       (head),
		.head_valid (head_valid),
		.pop        (pop),
		.axis       (axis),
		.axis_valid (axis_valid),
		.axis_ready (axis_ready)
	);

	rd_burst_issuer u_issuer (
		.clk       (clk),
		.rst_n     (rst_n),
		.job_load  (job_load),
		.job       (job),
		.launch_ok (launch_ok),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.launch    (launch)
	);

	rd_credit_ctrl u_credit (
		.clk           (clk),
		.rst_n         (rst_n),
		.launch        (launch),
		.rlast_done    (rlast_done),
		.burst_drained (burst_drained),
		.launch_ok     (launch_ok)
	);

	// rready is just room in the buffer
	rdata_fifo u_rdata_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (rvalid),
		.din       (r_in),
		.not_full  (rready),
		.rd        (pop),
		.dout      (head),
		.not_empty (head_valid)
	);

endmodule

`default_nettype wire

// File: design/rdata_fifo.sv
`default_nettype none

module rdata_fifo (
	input  wire                          clk,
	input  wire                          rst_n,
	// write side
	input  wire                          wr,
	input  wire dma_bus_pkg::r_beat_t    din,
	output logic                         not_full,
	// read side, head always shown
	input  wire                          rd,
	output dma_bus_pkg::r_beat_t         dout,
	output logic                         not_empty
);

	localparam int AW = dma_cfg_pkg::RDATA_AW;

	dma_bus_pkg::r_beat_t  mem [dma_cfg_pkg::RDATA_DEPTH];
	logic [AW:0]           wr_ptr;   // extra msb tells full from empty
	logic [AW:0]           rd_ptr;
	logic                  wr_en;
	logic                  rd_en;

	assign wr_en = wr & not_full;
	assign rd_en = rd & not_empty;

	assign not_empty = (wr_ptr != rd_ptr);
	// same index, other lap
	assign not_full  = !((wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]));

	// fall-through head
	assign dout = mem[rd_ptr[AW-1:0]];

	// storage
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	// pointers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// slot credits upstream keep occupancy below depth
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr |-> not_full)
		else $error("read data arrived with buffer full");

endmodule

`default_nettype wire

// File: design/rd_credit_ctrl.sv
`default_nettype none

module rd_credit_ctrl (
	input  wire   clk,
	input  wire   rst_n,
	input  wire   launch,          // ar handshake
	input  wire   rlast_done,      // rlast handshake
	input  wire   burst_drained,   // burst-last beat left the buffer
	output logic  launch_ok
);

	logic [dma_cfg_pkg::OUT_CR_W-1:0]   out_cr;     // free outstanding credits
	logic [dma_cfg_pkg::OUT_CR_W-1:0]   out_next;
	logic [dma_cfg_pkg::SLOT_CR_W-1:0]  slot_cr;    // free buffer slots
	logic [dma_cfg_pkg::SLOT_CR_W-1:0]  slot_next;

	// take on launch, give back on return, both at once cancel
	always_comb
	begin
		out_next = out_cr;
		if (launch && !rlast_done)
			out_next = out_cr - 1'b1;
		else if (!launch && rlast_done)
			out_next = out_cr + 1'b1;

		slot_next = slot_cr;
		if (launch && !burst_drained)
			slot_next = slot_cr - 1'b1;
		else if (!launch && burst_drained)
			slot_next = slot_cr + 1'b1;
	end

	// both pools full after reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_cr    <= dma_cfg_pkg::OUT_CR_W'(dma_cfg_pkg::RD_OUTSTANDING);
			slot_cr   <= dma_cfg_pkg::SLOT_CR_W'(dma_cfg_pkg::RDATA_SLOTS);
			launch_ok <= 1'b1;
		end
		else
		begin
			out_cr    <= out_next;
			slot_cr   <= slot_next;
			launch_ok <= (out_next != '0) && (slot_next != '0);  // from next counts
		end
	end

	// launch never spends a credit that is not there
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		launch |-> (out_cr != '0) && (slot_cr != '0))
		else $error("burst launched without credit");

	// returns never exceed what was taken
	a_out_limit: assert property (@(posedge clk) disable iff (!rst_n)
		rlast_done && !launch |-> out_cr < dma_cfg_pkg::RD_OUTSTANDING)
		else $error("rlast without an outstanding burst");

	a_slot_limit: assert property (@(posedge clk) disable iff (!rst_n)
		burst_drained && !launch |-> slot_cr < dma_cfg_pkg::RDATA_SLOTS)
		else $error("burst drained from buffer without a reserved slot");

endmodule

`default_nettype wire

// File: design/rd_burst_issuer.sv
`default_nettype none

module rd_burst_issuer (
	input  wire                       clk,
	input  wire                       rst_n,
	// new job
	input  wire                       job_load,
	input  wire dma_bus_pkg::job_t    job,
	// credit gate
	input  wire                       launch_ok,
	// axi read address
	output dma_bus_pkg::ar_beat_t     ar,
	output logic                      arvalid,
	input  wire                       arready,
	output logic                      launch     // burst accepted this cycle
);

	logic [dma_cfg_pkg::ADDR_W-1:0]   addr;        // next burst address
	logic [dma_cfg_pkg::BEATS_W-1:0]  remain_m1;   // beats left minus 1
	logic                             req;         // bursts still to send
	logic                             last_burst;
	logic [dma_cfg_pkg::LEN_W-1:0]    burst_len;

	// remainder fits into one burst
	assign last_burst = remain_m1 < dma_cfg_pkg::BEATS_W'(dma_cfg_pkg::MAX_BURST_LEN);
	assign burst_len  = last_burst ? remain_m1[dma_cfg_pkg::LEN_W-1:0] :
		dma_cfg_pkg::LEN_W'(dma_cfg_pkg::MAX_BURST_LEN - 1);

	assign ar      = '{addr: addr, len: burst_len};
	assign arvalid = req & launch_ok;   // credits must be in hand
	assign launch  = arvalid & arready;

	// request flag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			req <= 1'b0;
		else if (job_load)
			req <= 1'b1;
		else if (launch & last_burst)
			req <= 1'b0;   // stop until next job
	end

	// address and remaining beats
	always_ff @(posedge clk)
	begin
		if (job_load)
		begin
			addr      <= job.base;
			remain_m1 <= job.beats_m1;
		end
		else if (launch)
		begin
			addr      <= addr + dma_cfg_pkg::ADDR_W'(dma_cfg_pkg::BURST_BYTES);
			remain_m1 <= remain_m1 - dma_cfg_pkg::BEATS_W'(dma_cfg_pkg::MAX_BURST_LEN);
		end
	end

	// pending request keeps its content until taken
	a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("read address changed or dropped before arready");

	// a new job only starts after every burst of the last one went out
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		job_load |-> !req)
		else $error("job loaded while bursts still pending");

endmodule

`default_nettype wire

// File: design/mm2s_job_ctrl.sv
`default_nettype none

module mm2s_job_ctrl (
	input  wire                                 clk,
	input  wire                                 rst_n,
	// job command
	input  wire                                 start,
	input  wire [dma_cfg_pkg::ADDR_W-1:0]       base,
	input  wire [31:0]                          len,      // bytes minus 1
	output logic                                idle,
	output logic                                done,
	// to burst issuer
	output logic                                job_load,
	output dma_bus_pkg::job_t                   job,
	// buffer head
	input  wire dma_bus_pkg::r_beat_t           head,
	input  wire                                 head_valid,
	output logic                                pop,
	// stream out
	output dma_bus_pkg::axis_beat_t             axis,
	output logic                                axis_valid,
	input  wire                                 axis_ready
);

	dma_bus_pkg::job_state_e                 state;
	logic [dma_cfg_pkg::BEATS_W-1:0]         beats_m1;    // latched total minus 1
	logic [dma_cfg_pkg::BEATS_W-1:0]         beat_cnt;    // beats already streamed
	logic [dma_cfg_pkg::KEEP_W-1:0]          last_keep;   // byte enables of final beat
	logic [dma_cfg_pkg::BEATS_W-1:0]         len_beats_m1;
	logic [dma_cfg_pkg::BEAT_SHIFT-1:0]      keep_shift;
	logic                                    final_beat;

	// byte count to beat count
	assign len_beats_m1 = len[dma_cfg_pkg::BEAT_SHIFT +: dma_cfg_pkg::BEATS_W];
	// unused top bytes of the final beat, 7 - len[2:0]
	assign keep_shift = ~len[dma_cfg_pkg::BEAT_SHIFT-1:0];

	assign idle     = (state == dma_bus_pkg::IDLE);
	assign job_load = idle & start;   // start only counts while idle
	assign job      = '{base: base, beats_m1: len_beats_m1};

	// job state
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= dma_bus_pkg::IDLE;
		else
		begin
			case (state)
				dma_bus_pkg::IDLE:
				begin
					if (start)
						state <= dma_bus_pkg::RUN;
				end
				dma_bus_pkg::RUN:
				begin
					if (done)
						state <= dma_bus_pkg::IDLE;  // idle shows one cycle after done
				end
				default: state <= dma_bus_pkg::IDLE;
			endcase
		end
	end

	// job parameters, held for the whole run
	always_ff @(posedge clk)
	begin
		if (job_load)
		begin
			beats_m1  <= len_beats_m1;
			last_keep <= {dma_cfg_pkg::KEEP_W{1'b1}} >> keep_shift;
		end
	end

	// streamed beat counter
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			beat_cnt <= '0;
		else if (job_load)
			beat_cnt <= '0;
		else if (pop)
			beat_cnt <= beat_cnt + 1'b1;
	end

	assign final_beat = (beat_cnt == beats_m1);

	// head of buffer goes straight out
	assign axis_valid = head_valid;
	assign pop        = head_valid & axis_ready;
	assign axis       = '{
		data: head.data,
		keep: final_beat ? last_keep : {dma_cfg_pkg::KEEP_W{1'b1}},  // full except at the end
		last: final_beat
	};

	assign done = pop & final_beat;   // one pulse on the final handshake

	// data only arrives for bursts of a running job
	a_no_beat_idle: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> state == dma_bus_pkg::RUN)
		else $error("stream beat accepted while idle");

endmodule

`default_nettype wire

// File: design/dma_bus_pkg.sv
`default_nettype none

package dma_bus_pkg;

	// read address request
	typedef struct packed {
		logic [dma_cfg_pkg::ADDR_W-1:0] addr;
		logic [dma_cfg_pkg::LEN_W-1:0]  len;     // beats minus 1
	} ar_beat_t;

	// read data beat as stored in the buffer
	typedef struct packed {
		logic [dma_cfg_pkg::DATA_W-1:0] data;
		logic                           last;    // last beat of its burst
	} r_beat_t;

	// stream beat toward the upsampler
	typedef struct packed {
		logic [dma_cfg_pkg::DATA_W-1:0] data;
		logic [dma_cfg_pkg::KEEP_W-1:0] keep;
		logic                           last;    // last beat of the feature map
	} axis_beat_t;

	// job handed from control to the burst issuer
	typedef struct packed {
		logic [dma_cfg_pkg::ADDR_W-1:0]  base;
		logic [dma_cfg_pkg::BEATS_W-1:0] beats_m1;  // total beats minus 1
	} job_t;

	typedef enum logic {
		IDLE,
		RUN
	} job_state_e;

endpackage

`default_nettype wire

// File: design/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;            // one enable per byte
	localparam int BEAT_SHIFT = $clog2(KEEP_W);    // byte count to beat count

	// burst shaping
	localparam int MAX_BURST_LEN = 8;              // beats per full burst
	localparam int BURST_BYTES = MAX_BURST_LEN * KEEP_W;  // address step
	localparam int LEN_W = 8;                      // axi arlen field
	localparam int BEATS_W = 9;                    // up to 512 beats per job

	// in-flight limit on the read address channel
	localparam int RD_OUTSTANDING = 4;
	localparam int OUT_CR_W = $clog2(RD_OUTSTANDING + 1);

	// read-data buffer
	localparam int RDATA_DEPTH = 64;
	localparam int RDATA_AW = $clog2(RDATA_DEPTH);
	localparam int RDATA_SLOTS = RDATA_DEPTH / MAX_BURST_LEN;  // whole bursts that fit
	localparam int SLOT_CR_W = $clog2(RDATA_SLOTS + 1);

endpackage

`default_nettype wire
